// ==== vlog.f ====
+incdir+hdl
hdl/sha_pkg.sv
hdl/sha_msg_packer.sv
hdl/sha_word_fifo.sv
hdl/sha_k_rom.sv
hdl/sha_compressor.sv
hdl/sha_stream_top.sv
sim/sha_props.sv
sim/sha_tb.sv

// ==== sim/sha_trace.txt ====
# U nbytes word repeat gaps | F | H digest | W wait for digests | G message count
# gaps 1 puts 0 to 3 random idle cycles before each strobe, gaps 0 none
G 7
# Empty message
F
H e3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855
W
# abc, final beat of 3 bytes
U 3 61626300 1 1
F
H ba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad
W
# 56 bytes, length goes in a block of its own
U 4 61626364 1 1
U 4 62636465 1 1
U 4 63646566 1 1
U 4 64656667 1 1
U 4 65666768 1 1
U 4 66676869 1 1
U 4 6768696a 1 1
U 4 68696a6b 1 1
U 4 696a6b6c 1 1
U 4 6a6b6c6d 1 1
U 4 6b6c6d6e 1 1
U 4 6c6d6e6f 1 1
U 4 6d6e6f70 1 1
U 4 6e6f7071 1 1
F
H 248d6a61d20638b8e5c026930c3e6039a33ce45964ff2167f6ecedd419db06c1
W
# 1000 bytes of a, sixteen chained blocks
U 4 61616161 250 1
F
H 41edece42d63e8d9bf515a9ba6932e1c20cbc9f5a5d134645adb5db1b9737ea3
W
# Back to back, final beats of 1, 2 and 1 bytes
U 1 61000000 1 0
F
H ca978112ca1bbdcafac231b39a23dc4da786eff8147c4e72b9807785afee48bb
U 2 61620000 1 0
F
H fb8e20fc2e4c3f248c60c39bd652f3c1347298bb977b8b4d5903b85055620603
U 4 68656c6c 1 0
U 1 6f000000 1 0
F
H 2cf24dba5fb0a30e26e83b2ac5b9e29e1b161e5c1fa7425e73043362938b9824
W

// ==== sim/sha_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_tb import sha_pkg::*; ();

	logic    clk;
	logic    rst_n;
	logic    update;
	logic    finalize;
	word_t   data_in;
	nbytes_t bytes_valid;
	logic    fifo_full;
	logic    fifo_half_full;
	logic    hash_valid;
	digest_t hash;

	// Trace contents, one slot per command line
	byte     cmd_q[$];
	int      num_q[$];
	word_t   word_q[$];
	int      rep_q[$];
	int      gap_q[$];
	digest_t dig_q[$];
	int      msg_total = 0;
	int      beat_total = 0;

	// Digests sent but not yet returned
	digest_t exp_q[$];
	int      n_sent = 0;
	int      n_seen = 0;

	int          digest_errs = 0;
	int          flag_errs = 0;
	int          other_errs = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] lcg_state;
	logic        use_gaps;
	logic        seen_half = 1'b0;
	logic        seen_full = 1'b0;

	sha_stream_top u_dut (
		.clk, .rst_n, .update, .data_in, .bytes_valid, .finalize,
		.fifo_full, .fifo_half_full, .hash_valid, .hash
	);

	bind sha_stream_top sha_props u_props (
		.clk, .rst_n, .update, .finalize, .fifo_full, .hash_valid
	);

	//////////////////////////////////////////////////////////////////////
	// Clock and watchdog

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count++;

	// Budget known once the trace is read
	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit)
			@(posedge clk);
		$display("Timeout: no digest arrived before the limit of %0d cycles",
			cycle_limit);
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_digest(input digest_t exp, input digest_t act);
		if (act !== exp) begin
			digest_errs++;
			$display("ERROR at %0t: hash expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errs++;
			$display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// Random idle cycles, then hold off on a full FIFO
	task automatic idle_gap();
		int n;
		n = 0;
		if (use_gaps) begin
			lcg_state = lcg_next(lcg_state);
			n = int'(lcg_state[17:16]);
		end
		repeat (n) begin
			@(posedge clk);
			#2;
		end
		while (fifo_full) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_beat(input nbytes_t n, input word_t d);
		idle_gap();
		update = 1'b1;
		bytes_valid = n;
		data_in = d;
		@(posedge clk);
		#2;
		update = 1'b0;
	endtask

	task automatic send_finalize();
		idle_gap();
		finalize = 1'b1;
		@(posedge clk);
		#2;
		finalize = 1'b0;
	endtask

	task automatic wait_digests();
		wait (n_seen >= n_sent);
		@(posedge clk);
		#2;
	endtask

	// Whole trace into the queues before the run starts
	task automatic read_trace();
		int      fd;
		string   line;
		byte     c;
		int      n;
		word_t   w;
		int      rep;
		int      gap;
		digest_t d;
		fd = $fopen("sim/sha_trace.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("Cannot open the trace file sim/sha_trace.txt");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
				continue;
			c = line[0];
			n = 0;
			w = '0;
			rep = 0;
			gap = 0;
			d = '0;
			case (c)
				"U": begin
					void'($sscanf(line, "U %d %h %d %d", n, w, rep, gap));
					beat_total += rep;
				end
				"H": void'($sscanf(line, "H %h", d));
				"G": begin
					void'($sscanf(line, "G %d", n));
					msg_total = n;
				end
				"F", "W": begin
				end
				default: continue;
			endcase
			cmd_q.push_back(c);
			num_q.push_back(n);
			word_q.push_back(w);
			rep_q.push_back(rep);
			gap_q.push_back(gap);
			dig_q.push_back(d);
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle

	always @(negedge clk) begin
		if (rst_n) begin
			seen_half = seen_half | fifo_half_full;
			seen_full = seen_full | fifo_full;
			if (hash_valid) begin
				if (exp_q.size() == 0) begin
					other_errs++;
					$display("hash_valid pulsed at %0t with no digest expected", $time);
				end else begin
					check_digest(exp_q.pop_front(), hash);
					n_seen++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin : main
		int i;
		int r;
		rst_n = 1'b0;
		update = 1'b0;
		finalize = 1'b0;
		data_in = '0;
		bytes_valid = '0;
		lcg_state = 32'hfdb7_3636;
		use_gaps = 1'b1;
		read_trace();
		if (cmd_q.size() == 0) begin
			other_errs++;
			$display("The trace gave no commands");
		end
		cycle_limit = 16 + 400 * msg_total + 4 * beat_total;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Quiet outputs after reset
		check_bit("hash_valid", 1'b0, hash_valid);
		check_bit("fifo_full", 1'b0, fifo_full);
		check_bit("fifo_half_full", 1'b0, fifo_half_full);
		check_digest('0, hash);
		for (i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"U": begin
					use_gaps = (gap_q[i] != 0);
					for (r = 0; r < rep_q[i]; r++)
						send_beat(nbytes_t'(num_q[i]), word_q[i]);
				end
				"F": send_finalize();
				"H": begin
					exp_q.push_back(dig_q[i]);
					n_sent++;
				end
				"W": wait_digests();
				default: begin
				end
			endcase
		end
		wait_digests();
		// Long stream must have backed up the FIFO
		check_bit("fifo_half_full seen", 1'b1, seen_half);
		check_bit("fifo_full seen", 1'b1, seen_full);
		if (n_sent != msg_total) begin
			other_errs++;
			$display("The trace held %0d expected digests but announced %0d messages",
				n_sent, msg_total);
		end
		other_errs += u_dut.u_props.fail_count;
		$display("Errors: digest %0d, flag %0d, other %0d",
			digest_errs, flag_errs, other_errs);
		if (digest_errs + flag_errs + other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/sha_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_props (
	input wire clk,
	input wire rst_n,
	input wire update,
	input wire finalize,
	input wire fifo_full,
	input wire hash_valid
);

	// Assertion failures so far
	int fail_count = 0;

	// Source holds off while the FIFO is full
	a_no_strobe_full: assert property (@(posedge clk) disable iff (!rst_n)
		(update || finalize) |-> !fifo_full)
	else begin
		fail_count++;
		$error("update or finalize strobed while fifo_full is high");
	end

	// Digest strobe lasts one cycle
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		hash_valid |=> !hash_valid)
	else begin
		fail_count++;
		$error("hash_valid high two cycles in a row");
	end

	// One strobe kind per cycle
	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(update && finalize))
	else begin
		fail_count++;
		$error("update and finalize strobed in the same cycle");
	end

endmodule

`default_nettype wire

// ==== hdl/sha_stream_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_stream_top import sha_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         update,
	input  wire word_t   data_in,
	input  wire nbytes_t bytes_valid,
	input  wire         finalize,
	output logic        fifo_full,
	output logic        fifo_half_full,
	output logic        hash_valid,
	output digest_t     hash
);

	// Packer to FIFO
	logic        push;
	word_entry_t push_entry;

	// FIFO to compressor
	logic        pop;
	word_entry_t head;
	fifo_cnt_t   fifo_count;

	// ROM lookup
	round_t k_index;
	word_t  k_value;

	// Producer, tags the final word
	sha_msg_packer u_packer (
		.clk, .rst_n, .update, .data_in, .bytes_valid, .finalize,
		.push, .push_entry
	);

	// Buffer between packer and compressor
	sha_word_fifo u_fifo (
		.clk, .rst_n, .push, .push_entry, .pop,
		.head, .fifo_count, .fifo_full, .fifo_half_full
	);

	sha_k_rom u_k_rom (
		.clk, .k_index, .k_value
	);

	// Consumer, padding and rounds
	sha_compressor u_comp (
		.clk, .rst_n, .head, .fifo_count, .pop,
		.k_index, .k_value, .hash_valid, .hash
	);

endmodule

`default_nettype wire

// ==== hdl/sha_compressor.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_compressor import sha_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire word_entry_t head,
	input  wire fifo_cnt_t   fifo_count,
	output logic        pop,
	output round_t      k_index,
	input  wire word_t       k_value,
	output logic        hash_valid,
	output digest_t     hash
);

	// Initial hash values H0..H7
	localparam word_t IV [8] = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	comp_state_t state;

	// Message schedule window, w[0] is W[t] during rounds
	word_t w [16];
	// Working a..h and chaining H0..H7
	word_t wv [8];
	word_t hv [8];
	word_t hsum [8];

	logic [3:0] widx;
	round_t     round;
	len_t       msg_len;
	// Current block carries the length
	logic       final_blk;
	// Length block still owed
	logic       len_pending;

	logic  need_len_blk;
	word_t keep_mask;
	word_t pad_bits;
	word_t len_hi;
	word_t len_lo;
	word_t t1;
	word_t t2;
	word_t w_next;

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Padding helpers

	// 0x80 and length do not both fit, or data filled the block
	assign need_len_blk = (msg_len[5:0] > 6'd55) ||
		((msg_len[5:0] == 6'd0) && (msg_len != '0));

	// Bit length, big-endian 64 bits
	assign len_hi = {29'd0, msg_len[31:29]};
	assign len_lo = {msg_len[28:0], 3'd0};

	// Byte position of the 0x80 marker
	always_comb begin
		case (msg_len[1:0])
			2'd0: begin
				keep_mask = 32'h0000_0000;
				pad_bits  = 32'h8000_0000;
			end
			2'd1: begin
				keep_mask = 32'hff00_0000;
				pad_bits  = 32'h0080_0000;
			end
			2'd2: begin
				keep_mask = 32'hffff_0000;
				pad_bits  = 32'h0000_8000;
			end
			default: begin
				keep_mask = 32'hffff_ff00;
				pad_bits  = 32'h0000_0080;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Round datapath

	always_comb begin
		// T1 from e, f, g, h plus K and W
		t1 = wv[7] + (rotr(wv[4], 6) ^ rotr(wv[4], 11) ^ rotr(wv[4], 25)) +
			((wv[4] & wv[5]) ^ (~wv[4] & wv[6])) + k_value + w[0];
		// T2 from a, b, c
		t2 = (rotr(wv[0], 2) ^ rotr(wv[0], 13) ^ rotr(wv[0], 22)) +
			((wv[0] & wv[1]) ^ (wv[0] & wv[2]) ^ (wv[1] & wv[2]));
		// W[t+16] for the schedule
		w_next = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9] +
			(rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
		for (int i = 0; i < 8; i++)
			hsum[i] = hv[i] + wv[i];
	end

	// Stall on empty FIFO
	assign pop = (state == FILL) && (fifo_count != '0);

	// K for round r+1 is fetched during round r
	assign k_index = (state == ROUND) ? round + 6'd1 : '0;

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				// New message, restart the chain
				if (fifo_count != '0)
					hv <= IV;
			end
			FILL: begin
				if (pop)
					w[widx] <= head.data;
			end
			PAD: begin
				// Marker after last byte, zeros behind it
				if (!((msg_len[5:0] == 6'd0) && (msg_len != '0))) begin
					for (int i = 0; i < 16; i++) begin
						if (i == int'(msg_len[5:2]))
							w[i] <= (w[i] & keep_mask) | pad_bits;
						else if (i > int'(msg_len[5:2]))
							w[i] <= '0;
					end
				end
				if (!need_len_blk) begin
					w[14] <= len_hi;
					w[15] <= len_lo;
				end
			end
			LEN_ONLY: begin
				// Marker here only when the data block was full
				w[0] <= (msg_len[5:0] == 6'd0) ? 32'h8000_0000 : 32'h0;
				for (int i = 1; i < 14; i++)
					w[i] <= '0;
				w[14] <= len_hi;
				w[15] <= len_lo;
			end
			PRE: begin
				wv <= hv;
			end
			ROUND: begin
				for (int i = 0; i < 15; i++)
					w[i] <= w[i + 1];
				w[15] <= w_next;
				wv[0] <= t1 + t2;
				wv[1] <= wv[0];
				wv[2] <= wv[1];
				wv[3] <= wv[2];
				wv[4] <= wv[3] + t1;
				wv[5] <= wv[4];
				wv[6] <= wv[5];
				wv[7] <= wv[6];
			end
			ADD: begin
				hv <= hsum;
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			widx        <= '0;
			round       <= '0;
			msg_len     <= '0;
			final_blk   <= 1'b0;
			len_pending <= 1'b0;
			hash_valid  <= 1'b0;
			hash        <= '0;
		end else begin
			hash_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (fifo_count != '0) begin
						msg_len     <= '0;
						widx        <= '0;
						final_blk   <= 1'b0;
						len_pending <= 1'b0;
						state       <= FILL;
					end
				end
				FILL: begin
					// widx wraps to 0 after a full block
					if (pop) begin
						msg_len <= msg_len + len_t'(head.nbytes);
						widx    <= widx + 4'd1;
						if (head.last)
							state <= PAD;
						else if (widx == 4'd15)
							state <= PRE;
					end
				end
				PAD: begin
					final_blk   <= !need_len_blk;
					len_pending <= need_len_blk;
					state       <= PRE;
				end
				PRE: begin
					round <= '0;
					state <= ROUND;
				end
				ROUND: begin
					round <= round + 6'd1;
					if (round == 6'd63)
						state <= ADD;
				end
				ADD: begin
					if (final_blk) begin
						hash_valid <= 1'b1;
						hash  <= {hsum[0], hsum[1], hsum[2], hsum[3],
							hsum[4], hsum[5], hsum[6], hsum[7]};
						state <= DONE;
					end else if (len_pending) begin
						state <= LEN_ONLY;
					end else begin
						state <= FILL;
					end
				end
				LEN_ONLY: begin
					final_blk   <= 1'b1;
					len_pending <= 1'b0;
					state       <= PRE;
				end
				default: begin
					// DONE, valid pulse is out
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sha_k_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_k_rom import sha_pkg::*; (
	input  wire    clk,
	input  wire round_t k_index,
	output word_t  k_value
);

	// Round constants, one clock from index to value
	always_ff @(posedge clk) begin
		case (k_index)
			6'd0:  k_value <= 32'h428a2f98;
			6'd1:  k_value <= 32'h71374491;
			6'd2:  k_value <= 32'hb5c0fbcf;
			6'd3:  k_value <= 32'he9b5dba5;
			6'd4:  k_value <= 32'h3956c25b;
			6'd5:  k_value <= 32'h59f111f1;
			6'd6:  k_value <= 32'h923f82a4;
			6'd7:  k_value <= 32'hab1c5ed5;
			6'd8:  k_value <= 32'hd807aa98;
			6'd9:  k_value <= 32'h12835b01;
			6'd10: k_value <= 32'h243185be;
			6'd11: k_value <= 32'h550c7dc3;
			6'd12: k_value <= 32'h72be5d74;
			6'd13: k_value <= 32'h80deb1fe;
			6'd14: k_value <= 32'h9bdc06a7;
			6'd15: k_value <= 32'hc19bf174;
			6'd16: k_value <= 32'he49b69c1;
			6'd17: k_value <= 32'hefbe4786;
			6'd18: k_value <= 32'h0fc19dc6;
			6'd19: k_value <= 32'h240ca1cc;
			6'd20: k_value <= 32'h2de92c6f;
			6'd21: k_value <= 32'h4a7484aa;
			6'd22: k_value <= 32'h5cb0a9dc;
			6'd23: k_value <= 32'h76f988da;
			6'd24: k_value <= 32'h983e5152;
			6'd25: k_value <= 32'ha831c66d;
			6'd26: k_value <= 32'hb00327c8;
			6'd27: k_value <= 32'hbf597fc7;
			6'd28: k_value <= 32'hc6e00bf3;
			6'd29: k_value <= 32'hd5a79147;
			6'd30: k_value <= 32'h06ca6351;
			6'd31: k_value <= 32'h14292967;
			6'd32: k_value <= 32'h27b70a85;
			6'd33: k_value <= 32'h2e1b2138;
			6'd34: k_value <= 32'h4d2c6dfc;
			6'd35: k_value <= 32'h53380d13;
			6'd36: k_value <= 32'h650a7354;
			6'd37: k_value <= 32'h766a0abb;
			6'd38: k_value <= 32'h81c2c92e;
			6'd39: k_value <= 32'h92722c85;
			6'd40: k_value <= 32'ha2bfe8a1;
			6'd41: k_value <= 32'ha81a664b;
			6'd42: k_value <= 32'hc24b8b70;
			6'd43: k_value <= 32'hc76c51a3;
			6'd44: k_value <= 32'hd192e819;
			6'd45: k_value <= 32'hd6990624;
			6'd46: k_value <= 32'hf40e3585;
			6'd47: k_value <= 32'h106aa070;
			6'd48: k_value <= 32'h19a4c116;
			6'd49: k_value <= 32'h1e376c08;
			6'd50: k_value <= 32'h2748774c;
			6'd51: k_value <= 32'h34b0bcb5;
			6'd52: k_value <= 32'h391c0cb3;
			6'd53: k_value <= 32'h4ed8aa4a;
			6'd54: k_value <= 32'h5b9cca4f;
			6'd55: k_value <= 32'h682e6ff3;
			6'd56: k_value <= 32'h748f82ee;
			6'd57: k_value <= 32'h78a5636f;
			6'd58: k_value <= 32'h84c87814;
			6'd59: k_value <= 32'h8cc70208;
			6'd60: k_value <= 32'h90befffa;
			6'd61: k_value <= 32'ha4506ceb;
			6'd62: k_value <= 32'hbef9a3f7;
			default: k_value <= 32'hc67178f2;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/sha_word_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sha_params.svh"

module sha_word_fifo import sha_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         push,
	input  wire word_entry_t push_entry,
	input  wire         pop,
	output word_entry_t head,
	output fifo_cnt_t   fifo_count,
	output logic        fifo_full,
	output logic        fifo_half_full
);

	localparam int AW = $clog2(`SHA_FIFO_DEPTH);

	// Entry storage
	word_entry_t mem [`SHA_FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	// Drop writes when full, ignore pops when empty
	assign do_push = push && !fifo_full;
	assign do_pop  = pop && (fifo_count != '0);

	// Oldest entry, shown without delay
	assign head = mem[rd_ptr];

	assign fifo_full      = (fifo_count == fifo_cnt_t'(`SHA_FIFO_DEPTH));
	assign fifo_half_full = (fifo_count >= fifo_cnt_t'(`SHA_HALF_MARK));

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	// Pointers and fill count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(`SHA_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(`SHA_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (do_push && !do_pop)
				fifo_count <= fifo_count + 1'b1;
			else if (do_pop && !do_push)
				fifo_count <= fifo_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sha_msg_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_msg_packer import sha_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         update,
	input  wire word_t   data_in,
	input  wire nbytes_t bytes_valid,
	input  wire         finalize,
	output logic        push,
	output word_entry_t push_entry
);

	// Holding register for the most recent beat
	word_t   hold_data;
	nbytes_t hold_nbytes;
	logic    hold_valid;

	// Clear the unused low bytes of a partial word
	function automatic word_t mask_bytes(input word_t d, input nbytes_t n);
		word_t keep;
		case (n)
			3'd1:    keep = 32'hff00_0000;
			3'd2:    keep = 32'hffff_0000;
			3'd3:    keep = 32'hffff_ff00;
			3'd4:    keep = 32'hffff_ffff;
			default: keep = 32'h0000_0000;
		endcase
		return d & keep;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Push side

	// Update releases the held beat, finalize always pushes
	assign push = finalize || (update && hold_valid);

	always_comb begin
		push_entry.data   = hold_data;
		push_entry.nbytes = hold_nbytes;
		push_entry.last   = finalize;
		// Empty message gets a zero-length last entry
		if (finalize && !hold_valid) begin
			push_entry.data   = '0;
			push_entry.nbytes = '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Holding register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
		end else if (finalize) begin
			hold_valid <= 1'b0;
		end else if (update) begin
			hold_valid <= 1'b1;
		end
	end

	// Beat payload
	always_ff @(posedge clk) begin
		if (update) begin
			hold_data   <= mask_bytes(data_in, bytes_valid);
			hold_nbytes <= bytes_valid;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sha_pkg.sv ====
`default_nettype none

package sha_pkg;

	`include "sha_params.svh"

	// Message or state word
	typedef logic [31:0] word_t;

	// Valid bytes in one word, 0 to 4
	typedef logic [2:0] nbytes_t;

	// Message length in bytes
	typedef logic [31:0] len_t;

	// Digest with H0 in the top bits
	typedef logic [255:0] digest_t;

	// Round index
	typedef logic [5:0] round_t;

	// FIFO fill count
	typedef logic [`SHA_FIFO_CW-1:0] fifo_cnt_t;

	// One FIFO entry, left aligned big-endian bytes
	typedef struct packed {
		word_t   data;
		nbytes_t nbytes;
		logic    last;
	} word_entry_t;

	// Compressor FSM
	typedef enum logic [2:0] {
		IDLE, FILL, PAD, PRE, ROUND, ADD, LEN_ONLY, DONE
	} comp_state_t;

endpackage

`default_nettype wire

// ==== hdl/sha_params.svh ====
`ifndef SHA_PARAMS_SVH
`define SHA_PARAMS_SVH

// FIFO capacity in entries
// One block accumulates while another is compressed, so 17 at least
`define SHA_FIFO_DEPTH 32

// Width of the fill count, holds 0 to SHA_FIFO_DEPTH
`define SHA_FIFO_CW 6

// Fill count at which half-full asserts
`define SHA_HALF_MARK 16

`endif
